// ==== design/graph_setup_defines.svh ====
// ------------------------------
// Graph setup constants
// ------------------------------

`ifndef GRAPH_SETUP_DEFINES_SVH
`define GRAPH_SETUP_DEFINES_SVH

// Datapath widths
`define GS_ADDR_WIDTH 32
`define GS_COUNT_WIDTH 16
`define GS_LINE_BYTES 64
`define GS_FIFO_DEPTH 8

// Host register map
`define GS_REG_ADDR_WIDTH 2
`define GS_REG_BASE 0
`define GS_REG_SIZE 1
`define GS_REG_CTRL 2

`endif

// ==== design/graph_setup_pkg.sv ====
// ------------------------------
// Graph setup types
// ------------------------------

`default_nettype none

`include "graph_setup_defines.svh"

package graph_setup_pkg;

    // Byte address of a cache line
    typedef logic [`GS_ADDR_WIDTH-1:0] line_addr_t;

    // Number of cache lines in a job
    typedef logic [`GS_COUNT_WIDTH-1:0] line_count_t;

    // Host register index
    typedef logic [`GS_REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_REQ_DONE
    } setup_state_t;

endpackage : graph_setup_pkg

`default_nettype wire

// ==== design/graph_setup_subsystem.sv ====
// ------------------------------
// Graph setup subsystem
// ------------------------------

`default_nettype none

`include "graph_setup_defines.svh"

module graph_setup_subsystem (
    input  logic                            ap_clk,
    input  logic                            setup_areset,
    input  logic                            cfg_wr_en,
    input  graph_setup_pkg::reg_addr_t      cfg_addr,
    input  logic [31:0]                     cfg_wr_data,
    output logic [31:0]                     cfg_rd_data,
    input  logic                            mem_req_pop,
    output logic                            mem_req_valid,
    output graph_setup_pkg::line_addr_t     mem_req_addr,
    output logic                            mem_req_empty,
    input  logic                            mem_resp_valid,
    output logic                            setup_busy,
    output logic                            setup_done
);

    logic                         desc_valid;
    graph_setup_pkg::line_addr_t  desc_base;
    graph_setup_pkg::line_count_t desc_size;
    logic                         engine_start;
    graph_setup_pkg::line_addr_t  cfg_base;
    graph_setup_pkg::line_count_t cfg_size;
    logic                         engine_ready;
    logic                         engine_done;
    logic                         req_push;
    graph_setup_pkg::line_addr_t  req_push_data;
    logic                         req_full;

    setup_config_regs setup_config_regs_inst (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_addr     (cfg_addr),
        .cfg_wr_data  (cfg_wr_data),
        .cfg_rd_data  (cfg_rd_data),
        .setup_busy   (setup_busy),
        .setup_done   (setup_done),
        .desc_valid   (desc_valid),
        .desc_base    (desc_base),
        .desc_size    (desc_size)
    );

    kernel_setup kernel_setup_inst (
        .ap_clk         (ap_clk),
        .setup_areset   (setup_areset),
        .desc_valid     (desc_valid),
        .desc_base      (desc_base),
        .desc_size      (desc_size),
        .mem_resp_valid (mem_resp_valid),
        .engine_ready   (engine_ready),
        .engine_done    (engine_done),
        .engine_start   (engine_start),
        .cfg_base       (cfg_base),
        .cfg_size       (cfg_size),
        .setup_busy     (setup_busy),
        .setup_done     (setup_done)
    );

    serial_read_engine serial_read_engine_inst (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .engine_start (engine_start),
        .cfg_base     (cfg_base),
        .cfg_size     (cfg_size),
        .full         (req_full),
        .push         (req_push),
        .push_data    (req_push_data),
        .engine_ready (engine_ready),
        .engine_done  (engine_done)
    );

    // Memory side pops requests from here
    request_fifo #(
        .WIDTH (`GS_ADDR_WIDTH),
        .DEPTH (`GS_FIFO_DEPTH)
    ) request_fifo_inst (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .push         (req_push),
        .push_data    (req_push_data),
        .pop          (mem_req_pop),
        .pop_data     (mem_req_addr),
        .pop_valid    (mem_req_valid),
        .full         (req_full),
        .empty        (mem_req_empty)
    );

endmodule : graph_setup_subsystem

`default_nettype wire

// ==== design/kernel_setup.sv ====
// ------------------------------
// Setup controller
// ------------------------------

`default_nettype none

module kernel_setup (
    input  logic                            ap_clk,
    input  logic                            setup_areset,
    input  logic                            desc_valid,
    input  graph_setup_pkg::line_addr_t     desc_base,
    input  graph_setup_pkg::line_count_t    desc_size,
    input  logic                            mem_resp_valid,
    input  logic                            engine_ready,
    input  logic                            engine_done,
    output logic                            engine_start,
    output graph_setup_pkg::line_addr_t     cfg_base,
    output graph_setup_pkg::line_count_t    cfg_size,
    output logic                            setup_busy,
    output logic                            setup_done
);

    graph_setup_pkg::setup_state_t current_state;
    graph_setup_pkg::setup_state_t next_state;
    graph_setup_pkg::line_count_t  resp_count;
    logic                          job_complete;

    // engine_done is stale while the start pulse is still in flight
    assign job_complete = engine_done && !engine_start && (resp_count == cfg_size);

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            current_state <= graph_setup_pkg::SETUP_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            graph_setup_pkg::SETUP_RESET: begin
                next_state = graph_setup_pkg::SETUP_IDLE;
            end
            graph_setup_pkg::SETUP_IDLE: begin
                if (desc_valid && engine_ready)
                    next_state = graph_setup_pkg::SETUP_REQ_START;
            end
            graph_setup_pkg::SETUP_REQ_START: begin
                next_state = graph_setup_pkg::SETUP_REQ_BUSY;
            end
            graph_setup_pkg::SETUP_REQ_BUSY: begin
                if (job_complete)
                    next_state = graph_setup_pkg::SETUP_REQ_DONE;
            end
            graph_setup_pkg::SETUP_REQ_DONE: begin
                // Hold done until host drops the run bit
                if (!desc_valid)
                    next_state = graph_setup_pkg::SETUP_IDLE;
            end
            default: next_state = graph_setup_pkg::SETUP_RESET;
        endcase
    end

    // Registered status and start pulse
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            engine_start <= 1'b0;
            setup_busy   <= 1'b0;
            setup_done   <= 1'b0;
        end else begin
            engine_start <= (current_state == graph_setup_pkg::SETUP_REQ_START);
            setup_busy   <= (next_state == graph_setup_pkg::SETUP_REQ_START) ||
                            (next_state == graph_setup_pkg::SETUP_REQ_BUSY);
            setup_done   <= (next_state == graph_setup_pkg::SETUP_REQ_DONE);
        end
    end

    // ------------------------------
    // Descriptor latch and responses
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            cfg_base   <= '0;
            cfg_size   <= '0;
            resp_count <= '0;
        end else if (current_state == graph_setup_pkg::SETUP_REQ_START) begin
            cfg_base   <= desc_base;
            cfg_size   <= desc_size;
            resp_count <= '0;
        end else if (current_state == graph_setup_pkg::SETUP_REQ_BUSY && mem_resp_valid) begin
            resp_count <= resp_count + 1'b1;
        end
    end

    // Memory side must not answer more lines than were requested
    a_resp_bounded : assert property (@(posedge ap_clk) disable iff (setup_areset)
        resp_count <= cfg_size);

endmodule : kernel_setup

`default_nettype wire

// ==== design/request_fifo.sv ====
// ------------------------------
// Request FIFO
// ------------------------------

`default_nettype none

module request_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             ap_clk,
    input  logic             setup_areset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             pop_valid,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= do_pop;
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
        if (do_pop)
            pop_data <= mem[rd_ptr];
    end

    a_no_push_full : assert property (@(posedge ap_clk) disable iff (setup_areset)
        push |-> !full);
    a_no_pop_empty : assert property (@(posedge ap_clk) disable iff (setup_areset)
        pop |-> !empty);

endmodule : request_fifo

`default_nettype wire

// ==== design/serial_read_engine.sv ====
// ------------------------------
// Serial read engine
// ------------------------------

`default_nettype none

`include "graph_setup_defines.svh"

module serial_read_engine (
    input  logic                            ap_clk,
    input  logic                            setup_areset,
    input  logic                            engine_start,
    input  graph_setup_pkg::line_addr_t     cfg_base,
    input  graph_setup_pkg::line_count_t    cfg_size,
    input  logic                            full,
    output logic                            push,
    output graph_setup_pkg::line_addr_t     push_data,
    output logic                            engine_ready,
    output logic                            engine_done
);

    logic                         active;
    graph_setup_pkg::line_addr_t  next_addr;
    graph_setup_pkg::line_count_t remaining;

    // One request per cycle while the FIFO has room
    assign push         = active && !full;
    assign push_data    = next_addr;
    assign engine_ready = !active;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            active      <= 1'b0;
            engine_done <= 1'b0;
            remaining   <= '0;
        end else if (engine_start) begin
            // Empty job finishes on the start pulse
            active      <= (cfg_size != '0);
            engine_done <= (cfg_size == '0);
            remaining   <= cfg_size;
        end else if (push) begin
            remaining <= remaining - 1'b1;
            if (remaining == graph_setup_pkg::line_count_t'(1)) begin
                active      <= 1'b0;
                engine_done <= 1'b1;
            end
        end
    end

    // Running line address
    always_ff @(posedge ap_clk) begin
        if (engine_start) begin
            next_addr <= cfg_base;
        end else if (push) begin
            next_addr <= next_addr + graph_setup_pkg::line_addr_t'(`GS_LINE_BYTES);
        end
    end

    // Controller never restarts a running engine
    a_push_in_job : assert property (@(posedge ap_clk) disable iff (setup_areset)
        push |-> !engine_start);

endmodule : serial_read_engine

`default_nettype wire

// ==== design/setup_config_regs.sv ====
// ------------------------------
// Host descriptor registers
// ------------------------------

`default_nettype none

`include "graph_setup_defines.svh"

module setup_config_regs (
    input  logic                            ap_clk,
    input  logic                            setup_areset,
    input  logic                            cfg_wr_en,
    input  graph_setup_pkg::reg_addr_t      cfg_addr,
    input  logic [31:0]                     cfg_wr_data,
    output logic [31:0]                     cfg_rd_data,
    input  logic                            setup_busy,
    input  logic                            setup_done,
    output logic                            desc_valid,
    output graph_setup_pkg::line_addr_t     desc_base,
    output graph_setup_pkg::line_count_t    desc_size
);

    // Write decode, run bit lives in bit 0 of the control register
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_base  <= '0;
            desc_size  <= '0;
            desc_valid <= 1'b0;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                graph_setup_pkg::reg_addr_t'(`GS_REG_BASE): desc_base  <= cfg_wr_data[`GS_ADDR_WIDTH-1:0];
                graph_setup_pkg::reg_addr_t'(`GS_REG_SIZE): desc_size  <= cfg_wr_data[`GS_COUNT_WIDTH-1:0];
                graph_setup_pkg::reg_addr_t'(`GS_REG_CTRL): desc_valid <= cfg_wr_data[0];
                default: ;
            endcase
        end
    end

    // Read-back mixes stored run bit with live status
    always_comb begin
        case (cfg_addr)
            graph_setup_pkg::reg_addr_t'(`GS_REG_BASE): cfg_rd_data = 32'(desc_base);
            graph_setup_pkg::reg_addr_t'(`GS_REG_SIZE): cfg_rd_data = 32'(desc_size);
            graph_setup_pkg::reg_addr_t'(`GS_REG_CTRL):
                cfg_rd_data = {29'd0, setup_done, setup_busy, desc_valid};
            default: cfg_rd_data = 32'd0;
        endcase
    end

endmodule : setup_config_regs

`default_nettype wire

// ==== graph_setup_subsystem.f ====
+incdir+design
design/graph_setup_pkg.sv
design/setup_config_regs.sv
design/kernel_setup.sv
design/serial_read_engine.sv
design/request_fifo.sv
design/graph_setup_subsystem.sv
sim/graph_setup_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the graph setup testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module graph_setup_tb \
        -f graph_setup_subsystem.f \
        --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vgraph_setup_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== sim/graph_setup_tb.sv ====
// ------------------------------
// Graph setup testbench
// ------------------------------

`default_nettype none

`include "graph_setup_defines.svh"

module graph_setup_tb;

    // Six tests of under 250 cycles each plus margin
    localparam int TIMEOUT_CYCLES  = 2000;
    localparam int JOB_WAIT_CYCLES = 250;
    localparam int RESP_DELAY      = 3;
    localparam graph_setup_pkg::reg_addr_t BASE_REG = graph_setup_pkg::reg_addr_t'(`GS_REG_BASE);
    localparam graph_setup_pkg::reg_addr_t SIZE_REG = graph_setup_pkg::reg_addr_t'(`GS_REG_SIZE);
    localparam graph_setup_pkg::reg_addr_t CTRL_REG = graph_setup_pkg::reg_addr_t'(`GS_REG_CTRL);

    logic                        ap_clk;
    logic                        setup_areset;
    logic                        cfg_wr_en;
    graph_setup_pkg::reg_addr_t  cfg_addr;
    logic [31:0]                 cfg_wr_data;
    logic [31:0]                 cfg_rd_data;
    // Memory model drives these two
    logic                        mem_req_pop = 1'b0;
    logic                        mem_resp_valid = 1'b0;
    logic                        mem_req_valid;
    graph_setup_pkg::line_addr_t mem_req_addr;
    logic                        mem_req_empty;
    logic                        setup_busy;
    logic                        setup_done;

    logic                        pop_enable;
    int                          cycle_count = 0;
    int                          resp_sent = 0;
    int                          error_count;
    int                          tests_run;
    int                          tests_failed;
    graph_setup_pkg::line_addr_t req_addrs[$];
    int                          resp_due[$];

    graph_setup_subsystem graph_setup_subsystem_inst (
        .ap_clk         (ap_clk),
        .setup_areset   (setup_areset),
        .cfg_wr_en      (cfg_wr_en),
        .cfg_addr       (cfg_addr),
        .cfg_wr_data    (cfg_wr_data),
        .cfg_rd_data    (cfg_rd_data),
        .mem_req_pop    (mem_req_pop),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_empty  (mem_req_empty),
        .mem_resp_valid (mem_resp_valid),
        .setup_busy     (setup_busy),
        .setup_done     (setup_done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------
    // Memory side model
    // ------------------------------
    always @(posedge ap_clk) begin
        if (setup_areset) begin
            mem_req_pop    <= 1'b0;
            mem_resp_valid <= 1'b0;
        end else begin
            // Pop every other cycle so a pop never lands on a FIFO that just drained
            mem_req_pop <= pop_enable && !mem_req_empty && !mem_req_pop;
            if (mem_req_valid) begin
                req_addrs.push_back(mem_req_addr);
                resp_due.push_back(cycle_count + RESP_DELAY);
            end
            if (resp_due.size() > 0 && resp_due[0] <= cycle_count) begin
                void'(resp_due.pop_front());
                mem_resp_valid <= 1'b1;
                resp_sent      <= resp_sent + 1;
            end else begin
                mem_resp_valid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected 0x%08h, actual 0x%08h", name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic require(input string name, input bit cond, input string message);
        assert (cond) else begin
            $display("Failure in %s: %s", name, message);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic write_reg(input graph_setup_pkg::reg_addr_t addr, input logic [31:0] data);
        @(posedge ap_clk);
        cfg_wr_en   <= 1'b1;
        cfg_addr    <= addr;
        cfg_wr_data <= data;
        @(posedge ap_clk);
        cfg_wr_en <= 1'b0;
    endtask

    // Combinational read port sampled one edge after the address
    task automatic read_reg(input graph_setup_pkg::reg_addr_t addr, output logic [31:0] data);
        @(posedge ap_clk);
        cfg_addr <= addr;
        @(posedge ap_clk);
        data = cfg_rd_data;
    endtask

    task automatic start_job(input logic [31:0] base, input logic [15:0] size);
        write_reg(BASE_REG, base);
        write_reg(SIZE_REG, {16'd0, size});
        write_reg(CTRL_REG, 32'd1);
    endtask

    task automatic wait_for_done(input string name, input int size, input int resp_start,
                                 output bit empty_dropped);
        int waited;
        bit busy_seen;
        waited        = 0;
        busy_seen     = 1'b0;
        empty_dropped = 1'b0;
        @(posedge ap_clk);
        while (!setup_done && waited < JOB_WAIT_CYCLES) begin
            busy_seen     = busy_seen | setup_busy;
            empty_dropped = empty_dropped | !mem_req_empty;
            waited++;
            @(posedge ap_clk);
        end
        require(name, setup_done, "setup_done did not rise before the job timeout");
        require(name, busy_seen, "setup_busy never rose during the job");
        compare_value(name, "setup_busy at done", 32'd0, 32'(setup_busy));
        compare_value(name, "responses before done", size, resp_sent - resp_start);
    endtask

    task automatic verify_addresses(input string name, input logic [31:0] base,
                                    input int size, input int first);
        logic [31:0] expected;
        compare_value(name, "request count", size, req_addrs.size() - first);
        for (int i = 0; i < size && first + i < req_addrs.size(); i++) begin
            expected = base + 32'(i * `GS_LINE_BYTES);
            compare_value(name, $sformatf("address %0d", i), expected, req_addrs[first + i]);
        end
    endtask

    task automatic stop_job(input string name);
        int waited;
        waited = 0;
        write_reg(CTRL_REG, 32'd0);
        while (setup_done && waited < 10) begin
            waited++;
            @(posedge ap_clk);
        end
        require(name, !setup_done, "setup_done stayed high after the run bit was cleared");
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic reset_state();
        string name;
        int errors_before;
        logic [31:0] data;
        name          = "reset_state";
        errors_before = error_count;
        @(posedge ap_clk);
        compare_value(name, "setup_busy", 32'd0, 32'(setup_busy));
        compare_value(name, "setup_done", 32'd0, 32'(setup_done));
        compare_value(name, "mem_req_empty", 32'd1, 32'(mem_req_empty));
        compare_value(name, "mem_req_valid", 32'd0, 32'(mem_req_valid));
        read_reg(BASE_REG, data);
        compare_value(name, "base register", 32'd0, data);
        read_reg(SIZE_REG, data);
        compare_value(name, "size register", 32'd0, data);
        read_reg(CTRL_REG, data);
        compare_value(name, "control register", 32'd0, data);
        report_test(name, errors_before);
    endtask

    task automatic register_readback();
        string name;
        int errors_before;
        logic [31:0] base;
        logic [31:0] data;
        name          = "register_readback";
        errors_before = error_count;
        base          = $urandom();
        write_reg(BASE_REG, base);
        write_reg(SIZE_REG, 32'h0000_5a3c);
        // Status bits 1 and 2 ignore host writes
        write_reg(CTRL_REG, 32'h0000_0006);
        read_reg(BASE_REG, data);
        compare_value(name, "base register", base, data);
        read_reg(SIZE_REG, data);
        compare_value(name, "size register", 32'h0000_5a3c, data);
        read_reg(CTRL_REG, data);
        compare_value(name, "control register", 32'd0, data);
        report_test(name, errors_before);
    endtask

    task automatic single_job();
        string name;
        int errors_before;
        int first;
        int resp_start;
        bit empty_dropped;
        logic [31:0] base;
        name          = "single_job";
        errors_before = error_count;
        base          = $urandom() & 32'hFFFF_FFC0;
        first         = req_addrs.size();
        resp_start    = resp_sent;
        pop_enable   <= 1'b1;
        start_job(base, 16'd4);
        wait_for_done(name, 4, resp_start, empty_dropped);
        verify_addresses(name, base, 4, first);
        stop_job(name);
        report_test(name, errors_before);
    endtask

    task automatic back_pressure();
        string name;
        int errors_before;
        int first;
        int resp_start;
        bit empty_dropped;
        logic [31:0] base;
        name          = "back_pressure";
        errors_before = error_count;
        base          = $urandom() & 32'hFFFF_FFC0;
        first         = req_addrs.size();
        resp_start    = resp_sent;
        pop_enable   <= 1'b0;
        start_job(base, 16'd12);
        // Long enough for the FIFO to fill and the engine to stall
        repeat (30) @(posedge ap_clk);
        compare_value(name, "mem_req_empty while stalled", 32'd0, 32'(mem_req_empty));
        compare_value(name, "requests seen while stalled", 32'd0, req_addrs.size() - first);
        compare_value(name, "setup_busy while stalled", 32'd1, 32'(setup_busy));
        compare_value(name, "setup_done while stalled", 32'd0, 32'(setup_done));
        pop_enable <= 1'b1;
        wait_for_done(name, 12, resp_start, empty_dropped);
        verify_addresses(name, base, 12, first);
        stop_job(name);
        report_test(name, errors_before);
    endtask

    task automatic done_hold_rerun();
        string name;
        int errors_before;
        int first;
        int resp_start;
        bit empty_dropped;
        bit held;
        logic [31:0] base;
        logic [31:0] data;
        name          = "done_hold_rerun";
        errors_before = error_count;
        base          = $urandom() & 32'hFFFF_FFC0;
        resp_start    = resp_sent;
        pop_enable   <= 1'b1;
        start_job(base, 16'd3);
        wait_for_done(name, 3, resp_start, empty_dropped);
        held = 1'b1;
        repeat (10) begin
            @(posedge ap_clk);
            held = held & setup_done;
        end
        require(name, held, "setup_done dropped while the run bit was still set");
        read_reg(CTRL_REG, data);
        compare_value(name, "control with done", 32'h0000_0005, data);
        stop_job(name);
        read_reg(CTRL_REG, data);
        compare_value(name, "control after clear", 32'd0, data);
        // Second job on a fresh base
        base       = $urandom() & 32'hFFFF_FFC0;
        first      = req_addrs.size();
        resp_start = resp_sent;
        start_job(base, 16'd5);
        wait_for_done(name, 5, resp_start, empty_dropped);
        verify_addresses(name, base, 5, first);
        stop_job(name);
        report_test(name, errors_before);
    endtask

    task automatic zero_size_job();
        string name;
        int errors_before;
        int first;
        int resp_start;
        bit empty_dropped;
        name          = "zero_size_job";
        errors_before = error_count;
        first         = req_addrs.size();
        resp_start    = resp_sent;
        pop_enable   <= 1'b1;
        start_job($urandom() & 32'hFFFF_FFC0, 16'd0);
        wait_for_done(name, 0, resp_start, empty_dropped);
        require(name, !empty_dropped, "mem_req_empty fell during an empty job");
        verify_addresses(name, 32'd0, 0, first);
        stop_job(name);
        compare_value(name, "mem_req_empty after job", 32'd1, 32'(mem_req_empty));
        report_test(name, errors_before);
    endtask

    initial begin
        setup_areset = 1'b1;
        cfg_wr_en    = 1'b0;
        cfg_addr     = '0;
        cfg_wr_data  = 32'd0;
        pop_enable   = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(1201));
        repeat (4) @(posedge ap_clk);
        setup_areset <= 1'b0;

        reset_state();
        register_readback();
        single_job();
        back_pressure();
        done_hold_rerun();
        zero_size_job();

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : graph_setup_tb

`default_nettype wire
